// File: Bender.yml
package:
  name: rv32i_backend

sources:
  - src/rv32i_pkg.sv
  - src/dmem_apb_if.sv
  - src/mem_access.sv
  - src/data_ram.sv
  - src/write_back.sv
  - src/regfile.sv
  - src/rv32i_backend.sv
  - target: test
    files:
      - tests/backend_checker.sv
      - tests/tb_backend.sv

// File: all.f
src/rv32i_pkg.sv
src/dmem_apb_if.sv
src/mem_access.sv
src/data_ram.sv
src/write_back.sv
src/regfile.sv
src/rv32i_backend.sv
tests/backend_checker.sv
tests/tb_backend.sv

// File: src/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram
    import rv32i_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    dmem_apb_if.completer dmem
);

    rv32i_word                       mem [dmem_words];
    logic [$clog2(dmem_words)-1:0]   word_idx;
    logic                            waited;

    assign word_idx = dmem.paddr[$clog2(dmem_words)+1:2];

    // Ready on the second access cycle
    assign dmem.pready = dmem.psel & dmem.penable & waited;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            waited <= 1'b0;
        else if (dmem.pready)
            waited <= 1'b0;
        else if (dmem.psel && dmem.penable)
            waited <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        // Read word fetched during the wait state
        if (dmem.psel && dmem.penable && !waited)
            dmem.prdata <= mem[word_idx];

        if (dmem.pready && dmem.pwrite)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (dmem.pstrb[i])
                    mem[word_idx][8*i +: 8] <= dmem.pwdata[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/dmem_apb_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dmem_apb_if
    import rv32i_pkg::*;
();

    logic       psel;
    logic       penable;
    logic       pwrite;
    rv32i_word  paddr;
    rv32i_word  pwdata;
    logic [3:0] pstrb;
    rv32i_word  prdata;
    logic       pready;

    modport requester
    (
        output psel, penable, pwrite, paddr, pwdata, pstrb,
        input  prdata, pready
    );

    modport completer
    (
        input  psel, penable, pwrite, paddr, pwdata, pstrb,
        output prdata, pready
    );

endinterface

`default_nettype wire

// File: src/mem_access.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access
    import rv32i_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        in_valid,
    input  wire rv32i_ctrl_t in_ctrl,
    input  wire rv32i_word   in_pc_plus4,
    input  wire rv32i_word   in_alu,
    input  wire logic        in_br_en,
    input  wire rv32i_word   in_store_data,
    dmem_apb_if.requester    dmem,
    output logic             in_ready,
    output logic             wb_valid,
    output rv32i_ctrl_t      wb_ctrl,
    output rv32i_word        wb_pc_plus4,
    output rv32i_word        wb_alu,
    output logic             wb_br_en,
    output rv32i_word        wb_rdata,
    output logic [3:0]       wb_byte_enable
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t      state;
    logic        s_valid;
    rv32i_ctrl_t s_ctrl;
    rv32i_word   s_pc_plus4;
    rv32i_word   s_alu;
    logic        s_br_en;
    rv32i_word   s_store_data;

    logic        accept;
    logic        s_is_mem;
    logic        done;
    logic        wb_load;
    logic [3:0]  byte_enable;
    logic [1:0]  lane;

    assign accept   = in_valid & in_ready;
    assign in_ready = (state == st_idle);
    assign s_is_mem = s_ctrl.mem_read | s_ctrl.mem_write;
    assign done     = (state == st_access) & dmem.pready;
    assign wb_load  = s_valid & (~s_is_mem | done);

    // Lane select from low address bits and access size
    always_comb
    begin
        lane        = 2'd0;
        byte_enable = 4'b1111;
        case (s_ctrl.mem_size)
            size_byte:
            begin
                lane        = s_alu[1:0];
                byte_enable = 4'b0001 << s_alu[1:0];
            end
            size_half:
            begin
                case (s_alu[1:0])
                    2'd1:    byte_enable = 4'b0110;
                    2'd2:    byte_enable = 4'b1100;
                    default: byte_enable = 4'b0011;
                endcase
                lane = (s_alu[1:0] == 2'd3) ? 2'd0 : s_alu[1:0];
            end
            default: ;
        endcase
    end

    assign dmem.psel    = (state != st_idle);
    assign dmem.penable = (state == st_access);
    assign dmem.pwrite  = s_ctrl.mem_write;
    assign dmem.paddr   = {s_alu[xlen-1:2], 2'b00};
    assign dmem.pwdata  = s_store_data << {lane, 3'b000};
    assign dmem.pstrb   = s_ctrl.mem_write ? byte_enable : 4'b0000;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= st_idle;
            s_valid  <= 1'b0;
            wb_valid <= 1'b0;
        end
        else
        begin
            if (accept)
                s_valid <= 1'b1;
            else if (wb_load)
                s_valid <= 1'b0;

            case (state)
                st_idle:
                    if (accept && (in_ctrl.mem_read || in_ctrl.mem_write))
                        state <= st_setup;
                st_setup:
                    state <= st_access;
                st_access:
                    if (dmem.pready)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase

            wb_valid <= wb_load;
        end
    end

    // Stage register
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s_ctrl       <= in_ctrl;
            s_pc_plus4   <= in_pc_plus4;
            s_alu        <= in_alu;
            s_br_en      <= in_br_en;
            s_store_data <= in_store_data;
        end
    end

    // MEM/WB register, read word kept unshifted
    always_ff @(posedge clk)
    begin
        if (wb_load)
        begin
            wb_ctrl        <= s_ctrl;
            wb_pc_plus4    <= s_pc_plus4;
            wb_alu         <= s_alu;
            wb_br_en       <= s_br_en;
            wb_rdata       <= dmem.prdata;
            wb_byte_enable <= byte_enable;
        end
    end

endmodule

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile
    import rv32i_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       load_regfile,
    input  wire logic [4:0] rd,
    input  wire rv32i_word  rd_data,
    input  wire logic [4:0] rs1_addr,
    input  wire logic [4:0] rs2_addr,
    output rv32i_word       rs1_data,
    output rv32i_word       rs2_data
);

    // x1..x31, x0 has no storage
    rv32i_word regs [1:31];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (load_regfile && (rd != 5'd0))
        begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: src/rv32i_backend.sv
`timescale 1ns/100ps
`default_nettype none

module rv32i_backend
    import rv32i_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            in_valid,
    input  wire logic            in_load_regfile,
    input  wire logic [4:0]      in_rd,
    input  wire regfilemux_sel_t in_regfilemux_sel,
    input  wire pcmux_sel_t      in_pcmux_sel,
    input  wire logic            in_mem_read,
    input  wire logic            in_mem_write,
    input  wire mem_size_t       in_mem_size,
    input  wire rv32i_word       in_u_imm,
    input  wire rv32i_word       in_pc_plus4,
    input  wire rv32i_word       in_alu,
    input  wire logic            in_br_en,
    input  wire rv32i_word       in_store_data,
    input  wire logic [4:0]      rs1_addr,
    input  wire logic [4:0]      rs2_addr,
    output logic                 in_ready,
    output rv32i_word            rs1_data,
    output rv32i_word            rs2_data,
    output logic                 wb_valid,
    output rv32i_word            pc_redirect,
    output pcmux_sel_t           pcmux_sel
);

    rv32i_ctrl_t in_ctrl;
    rv32i_ctrl_t wb_ctrl;
    rv32i_word   wb_pc_plus4;
    rv32i_word   wb_alu;
    logic        wb_br_en;
    rv32i_word   wb_rdata;
    logic [3:0]  wb_byte_enable;
    logic        load_regfile;
    logic [4:0]  rd;
    rv32i_word   rd_data;

    dmem_apb_if dmem_bus ();

    always_comb
    begin
        in_ctrl.load_regfile   = in_load_regfile;
        in_ctrl.rd             = in_rd;
        in_ctrl.regfilemux_sel = in_regfilemux_sel;
        in_ctrl.pcmux_sel      = in_pcmux_sel;
        in_ctrl.mem_read       = in_mem_read;
        in_ctrl.mem_write      = in_mem_write;
        in_ctrl.mem_size       = in_mem_size;
        in_ctrl.u_imm          = in_u_imm;
    end

    mem_access i_mem_access
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .in_valid       (in_valid),
        .in_ctrl        (in_ctrl),
        .in_pc_plus4    (in_pc_plus4),
        .in_alu         (in_alu),
        .in_br_en       (in_br_en),
        .in_store_data  (in_store_data),
        .dmem           (dmem_bus.requester),
        .in_ready       (in_ready),
        .wb_valid       (wb_valid),
        .wb_ctrl        (wb_ctrl),
        .wb_pc_plus4    (wb_pc_plus4),
        .wb_alu         (wb_alu),
        .wb_br_en       (wb_br_en),
        .wb_rdata       (wb_rdata),
        .wb_byte_enable (wb_byte_enable)
    );

    data_ram i_data_ram
    (
        .clk    (clk),
        .arst_n (arst_n),
        .dmem   (dmem_bus.completer)
    );

    write_back i_write_back
    (
        .wb_valid       (wb_valid),
        .wb_ctrl        (wb_ctrl),
        .wb_pc_plus4    (wb_pc_plus4),
        .wb_alu         (wb_alu),
        .wb_br_en       (wb_br_en),
        .wb_rdata       (wb_rdata),
        .wb_byte_enable (wb_byte_enable),
        .load_regfile   (load_regfile),
        .rd             (rd),
        .rd_data        (rd_data),
        .pc_redirect    (pc_redirect),
        .pcmux_sel      (pcmux_sel)
    );

    regfile i_regfile
    (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_regfile (load_regfile),
        .rd           (rd),
        .rd_data      (rd_data),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

endmodule

`default_nettype wire

// File: src/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    localparam int xlen       = 32;
    localparam int dmem_words = 256;

    typedef logic [xlen-1:0] rv32i_word;

    // Write-back source, loads also carry their format
    typedef enum logic [3:0] {
        rf_alu_out  = 4'd0,
        rf_br_en    = 4'd1,
        rf_u_imm    = 4'd2,
        rf_lw       = 4'd3,
        rf_pc_plus4 = 4'd4,
        rf_lb       = 4'd5,
        rf_lbu      = 4'd6,
        rf_lh       = 4'd7,
        rf_lhu      = 4'd8
    } regfilemux_sel_t;

    // Next fetch PC source
    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'd0,
        pcmux_alu_out  = 2'd1,
        pcmux_alu_mod2 = 2'd2
    } pcmux_sel_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    // Resolved control word handed down from execute
    typedef struct packed {
        logic            load_regfile;
        logic [4:0]      rd;
        regfilemux_sel_t regfilemux_sel;
        pcmux_sel_t      pcmux_sel;
        logic            mem_read;
        logic            mem_write;
        mem_size_t       mem_size;
        rv32i_word       u_imm;
    } rv32i_ctrl_t;

endpackage

`default_nettype wire

// File: src/write_back.sv
`timescale 1ns/100ps
`default_nettype none

module write_back
    import rv32i_pkg::*;
(
    input  wire logic        wb_valid,
    input  wire rv32i_ctrl_t wb_ctrl,
    input  wire rv32i_word   wb_pc_plus4,
    input  wire rv32i_word   wb_alu,
    input  wire logic        wb_br_en,
    input  wire rv32i_word   wb_rdata,
    input  wire logic [3:0]  wb_byte_enable,
    output logic             load_regfile,
    output logic [4:0]       rd,
    output rv32i_word        rd_data,
    output rv32i_word        pc_redirect,
    output pcmux_sel_t       pcmux_sel
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Redirect to fetch
    assign pc_redirect = wb_alu;
    assign pcmux_sel   = wb_ctrl.pcmux_sel;

    assign load_regfile = wb_valid & wb_ctrl.load_regfile;
    assign rd           = wb_ctrl.rd;

    // Lane picked by the one-hot byte enable
    always_comb
    begin
        case (wb_byte_enable)
            4'b0010: load_byte = wb_rdata[15:8];
            4'b0100: load_byte = wb_rdata[23:16];
            4'b1000: load_byte = wb_rdata[31:24];
            default: load_byte = wb_rdata[7:0];
        endcase
    end

    // Half starts at lowest set enable bit
    always_comb
    begin
        case (wb_byte_enable)
            4'b0110: load_half = wb_rdata[23:8];
            4'b1100: load_half = wb_rdata[31:16];
            default: load_half = wb_rdata[15:0];
        endcase
    end

    always_comb
    begin
        case (wb_ctrl.regfilemux_sel)
            rf_alu_out:  rd_data = wb_alu;
            rf_br_en:    rd_data = {{(xlen-1){1'b0}}, wb_br_en};
            rf_u_imm:    rd_data = wb_ctrl.u_imm;
            rf_lw:       rd_data = wb_rdata;
            rf_pc_plus4: rd_data = wb_pc_plus4;
            rf_lb:       rd_data = {{24{load_byte[7]}}, load_byte};
            rf_lbu:      rd_data = {24'd0, load_byte};
            rf_lh:       rd_data = {{16{load_half[15]}}, load_half};
            rf_lhu:      rd_data = {16'd0, load_half};
            default:     rd_data = wb_alu;
        endcase
    end

endmodule

`default_nettype wire

// File: tests/backend_checker.sv
`timescale 1ns/100ps
`default_nettype none

module backend_checker
    import rv32i_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       in_valid,
    input  wire logic       in_ready,
    input  wire logic       in_mem_read,
    input  wire logic       in_mem_write,
    input  wire rv32i_word  in_alu,
    input  wire pcmux_sel_t in_pcmux_sel,
    input  wire logic       wb_valid,
    input  wire rv32i_word  pc_redirect,
    input  wire pcmux_sel_t pcmux_sel,
    input  wire logic       check_en,
    input  wire logic [4:0] rs1_addr,
    input  wire logic [4:0] rs2_addr,
    input  wire rv32i_word  rs1_data,
    input  wire rv32i_word  rs2_data,
    input  wire rv32i_word  exp_rs1,
    input  wire rv32i_word  exp_rs2,
    output int              pending,
    output int              mismatch_errors,
    output int              other_errors
);

    // Instructions between accept and write-back, oldest first
    rv32i_word  q_alu [$];
    pcmux_sel_t q_pcmux [$];
    logic       q_mem [$];
    int         q_cyc [$];

    int         cyc;
    int         busy;
    rv32i_word  exp_alu;
    pcmux_sel_t exp_pcmux;
    logic       exp_mem;
    int         acc_cyc;
    int         latency;

    initial
    begin
        pending         = 0;
        mismatch_errors = 0;
        other_errors    = 0;
    end

    task automatic compare_word(string name, rv32i_word got, rv32i_word exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_errors++;
        end
    endtask

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            q_alu.delete();
            q_pcmux.delete();
            q_mem.delete();
            q_cyc.delete();
            cyc  = 0;
            busy = 0;
        end
        else
        begin
            cyc++;

            // in_ready stays low for the three cycles of a memory access
            if (busy > 0)
            begin
                if (in_ready)
                begin
                    $display("Error at %0t: in_ready high during a memory access", $time);
                    other_errors++;
                end
                busy--;
            end

            if (wb_valid)
            begin
                if (q_alu.size() == 0)
                begin
                    $display("Error at %0t: write-back with no instruction in flight", $time);
                    other_errors++;
                end
                else
                begin
                    exp_alu   = q_alu.pop_front();
                    exp_pcmux = q_pcmux.pop_front();
                    exp_mem   = q_mem.pop_front();
                    acc_cyc   = q_cyc.pop_front();
                    compare_word("pc_redirect", pc_redirect, exp_alu);
                    if (pcmux_sel !== exp_pcmux)
                    begin
                        $display("mismatch at %0t: pcmux_sel got %0d expected %0d",
                                 $time, pcmux_sel, exp_pcmux);
                        mismatch_errors++;
                    end
                    latency = exp_mem ? 4 : 2;
                    if (cyc - acc_cyc != latency)
                    begin
                        $display("Error at %0t: write-back came %0d cycles after accept, not %0d",
                                 $time, cyc - acc_cyc, latency);
                        other_errors++;
                    end
                end
            end

            if (in_valid && in_ready)
            begin
                q_alu.push_back(in_alu);
                q_pcmux.push_back(in_pcmux_sel);
                q_mem.push_back(in_mem_read | in_mem_write);
                q_cyc.push_back(cyc);
                if (in_mem_read || in_mem_write)
                    busy = 3;
            end

            if (check_en)
            begin
                compare_word($sformatf("rs1_data (x%0d)", rs1_addr), rs1_data, exp_rs1);
                compare_word($sformatf("rs2_data (x%0d)", rs2_addr), rs2_data, exp_rs2);
            end

            pending = q_alu.size();
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_backend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_backend
    import rv32i_pkg::*;
();

    // 40 + 8 + 16 + 24 + 14 + 30 instructions over all tests
    localparam int num_instr  = 132;
    localparam int max_cycles = 40 * num_instr;
    localparam int mem_span   = 16;

    logic            clk;
    logic            arst_n;
    logic            in_valid;
    logic            in_load_regfile;
    logic [4:0]      in_rd;
    regfilemux_sel_t in_regfilemux_sel;
    pcmux_sel_t      in_pcmux_sel;
    logic            in_mem_read;
    logic            in_mem_write;
    mem_size_t       in_mem_size;
    rv32i_word       in_u_imm;
    rv32i_word       in_pc_plus4;
    rv32i_word       in_alu;
    logic            in_br_en;
    rv32i_word       in_store_data;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic            in_ready;
    rv32i_word       rs1_data;
    rv32i_word       rs2_data;
    logic            wb_valid;
    rv32i_word       pc_redirect;
    pcmux_sel_t      pcmux_sel;

    logic            check_en;
    rv32i_word       exp_rs1;
    rv32i_word       exp_rs2;
    int              pending;
    int              mismatch_errors;
    int              other_errors;

    integer          seed;
    int              cycles = 0;
    rv32i_word       reg_model [32];
    rv32i_word       mem_model [mem_span];

    rv32i_backend i_dut
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .in_valid          (in_valid),
        .in_load_regfile   (in_load_regfile),
        .in_rd             (in_rd),
        .in_regfilemux_sel (in_regfilemux_sel),
        .in_pcmux_sel      (in_pcmux_sel),
        .in_mem_read       (in_mem_read),
        .in_mem_write      (in_mem_write),
        .in_mem_size       (in_mem_size),
        .in_u_imm          (in_u_imm),
        .in_pc_plus4       (in_pc_plus4),
        .in_alu            (in_alu),
        .in_br_en          (in_br_en),
        .in_store_data     (in_store_data),
        .rs1_addr          (rs1_addr),
        .rs2_addr          (rs2_addr),
        .in_ready          (in_ready),
        .rs1_data          (rs1_data),
        .rs2_data          (rs2_data),
        .wb_valid          (wb_valid),
        .pc_redirect       (pc_redirect),
        .pcmux_sel         (pcmux_sel)
    );

    backend_checker i_checker
    (
        .clk             (clk),
        .arst_n          (arst_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_mem_read     (in_mem_read),
        .in_mem_write    (in_mem_write),
        .in_alu          (in_alu),
        .in_pcmux_sel    (in_pcmux_sel),
        .wb_valid        (wb_valid),
        .pc_redirect     (pc_redirect),
        .pcmux_sel       (pcmux_sel),
        .check_en        (check_en),
        .rs1_addr        (rs1_addr),
        .rs2_addr        (rs2_addr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .exp_rs1         (exp_rs1),
        .exp_rs2         (exp_rs2),
        .pending         (pending),
        .mismatch_errors (mismatch_errors),
        .other_errors    (other_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic rv32i_word rand_word();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rd_rand();
        rv32i_word w;
        w = rand_word();
        return w[4:0];
    endfunction

    function automatic logic [4:0] rd_nonzero();
        rv32i_word w;
        w = rand_word() % 31 + 1;
        return w[4:0];
    endfunction

    function automatic rv32i_word word_addr();
        return (rand_word() % mem_span) * 4;
    endfunction

    function automatic regfilemux_sel_t non_mem_sel(int k);
        case (k)
            0:       return rf_alu_out;
            1:       return rf_br_en;
            2:       return rf_u_imm;
            default: return rf_pc_plus4;
        endcase
    endfunction

    // Expected rd value, load lanes taken from the address offset
    function automatic rv32i_word expected_rd(regfilemux_sel_t sel, rv32i_word alu,
                                              logic br_en, rv32i_word u_imm,
                                              rv32i_word pc4, rv32i_word word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*alu[1:0] +: 8];
        case (alu[1:0])
            2'd1:    h = word[23:8];
            2'd2:    h = word[31:16];
            default: h = word[15:0];
        endcase
        case (sel)
            rf_alu_out:  return alu;
            rf_br_en:    return {31'd0, br_en};
            rf_u_imm:    return u_imm;
            rf_pc_plus4: return pc4;
            rf_lw:       return word;
            rf_lb:       return {{24{b[7]}}, b};
            rf_lbu:      return {24'd0, b};
            rf_lh:       return {{16{h[15]}}, h};
            rf_lhu:      return {16'd0, h};
            default:     return alu;
        endcase
    endfunction

    task automatic store_model(mem_size_t size, rv32i_word addr, rv32i_word data);
        int idx;
        int off;
        idx = addr[5:2];
        off = addr[1:0];
        case (size)
            size_byte:
                mem_model[idx][8*off +: 8] = data[7:0];
            size_half:
            begin
                // Offset 3 falls back to the low half
                if (off == 3)
                    mem_model[idx][15:0] = data[15:0];
                else
                    mem_model[idx][8*off +: 16] = data[15:0];
            end
            default:
                mem_model[idx] = data;
        endcase
    endtask

    task automatic issue(regfilemux_sel_t sel, logic [4:0] rd, logic load, logic rd_mem,
                         logic wr_mem, mem_size_t size, rv32i_word alu, rv32i_word data);
        rv32i_word u_imm;
        rv32i_word pc4;
        rv32i_word rnd;
        rv32i_word result;
        u_imm = rand_word() & 32'hffff_f000;
        pc4   = rand_word();
        rnd   = rand_word();
        in_valid          = 1'b1;
        in_load_regfile   = load;
        in_rd             = rd;
        in_regfilemux_sel = sel;
        in_pcmux_sel      = pcmux_sel_t'(rnd % 3);
        in_mem_read       = rd_mem;
        in_mem_write      = wr_mem;
        in_mem_size       = size;
        in_u_imm          = u_imm;
        in_pc_plus4       = pc4;
        in_alu            = alu;
        in_br_en          = rnd[8];
        in_store_data     = data;
        do
            @(posedge clk);
        while (!in_ready);
        result = expected_rd(sel, alu, rnd[8], u_imm, pc4, mem_model[alu[5:2]]);
        if (wr_mem)
            store_model(size, alu, data);
        if (load && rd != 5'd0)
            reg_model[rd] = result;
        #10;
        in_valid = 1'b0;
    endtask

    task automatic alu_op(regfilemux_sel_t sel, logic [4:0] rd, logic load);
        issue(sel, rd, load, 1'b0, 1'b0, size_word, rand_word(), rand_word());
    endtask

    task automatic store(mem_size_t size, rv32i_word addr, rv32i_word data);
        issue(rf_alu_out, rd_rand(), 1'b0, 1'b0, 1'b1, size, addr, data);
    endtask

    task automatic load(regfilemux_sel_t sel, logic [4:0] rd, rv32i_word addr);
        mem_size_t size;
        case (sel)
            rf_lb, rf_lbu: size = size_byte;
            rf_lh, rf_lhu: size = size_half;
            default:       size = size_word;
        endcase
        issue(sel, rd, 1'b1, 1'b1, 1'b0, size, addr, rand_word());
    endtask

    task automatic drain();
        while (pending != 0)
        begin
            @(posedge clk);
            #10;
        end
    endtask

    // Read all registers back two at a time
    task automatic check_regs();
        drain();
        for (int i = 0; i < 32; i += 2)
        begin
            rs1_addr = i;
            rs2_addr = i + 1;
            exp_rs1  = reg_model[i];
            exp_rs2  = reg_model[i+1];
            check_en = 1'b1;
            @(posedge clk);
            #10;
        end
        check_en = 1'b0;
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles)
        begin
            $display("Timeout: run exceeded %0d cycles", max_cycles);
            $display("Error counts: %0d mismatches, %0d other failures, 1 timeout",
                     mismatch_errors, other_errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial
    begin
        seed              = 55;
        arst_n            = 1'b0;
        in_valid          = 1'b0;
        in_load_regfile   = 1'b0;
        in_rd             = 5'd0;
        in_regfilemux_sel = rf_alu_out;
        in_pcmux_sel      = pcmux_pc_plus4;
        in_mem_read       = 1'b0;
        in_mem_write      = 1'b0;
        in_mem_size       = size_word;
        in_u_imm          = '0;
        in_pc_plus4       = '0;
        in_alu            = '0;
        in_br_en          = 1'b0;
        in_store_data     = '0;
        rs1_addr          = 5'd0;
        rs2_addr          = 5'd0;
        check_en          = 1'b0;
        exp_rs1           = '0;
        exp_rs2           = '0;
        for (int i = 0; i < 32; i++)
            reg_model[i] = '0;
        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;

        // Non-memory write-back sources
        for (int i = 0; i < 40; i++)
            alu_op(non_mem_sel(rand_word() % 4), rd_rand(), 1'b1);
        check_regs();

        // x0 and load_regfile low leave registers alone
        for (int i = 0; i < 4; i++)
            alu_op(rf_alu_out, 5'd0, 1'b1);
        for (int i = 0; i < 4; i++)
            alu_op(rf_u_imm, rd_nonzero(), 1'b0);
        check_regs();

        // Fill the test region, then partial stores read back with lw
        for (int w = 0; w < mem_span; w++)
            store(size_word, w * 4, rand_word());
        for (int s = 0; s < 3; s++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                rv32i_word addr;
                addr = word_addr() + off;
                store(mem_size_t'(s), addr, rand_word());
                load(rf_lw, rd_nonzero(), addr & ~32'h3);
            end
        end
        check_regs();

        // Narrow loads at each legal offset
        for (int off = 0; off < 4; off++)
        begin
            load(rf_lb, rd_nonzero(), word_addr() + off);
            load(rf_lbu, rd_nonzero(), word_addr() + off);
        end
        for (int off = 0; off < 3; off++)
        begin
            load(rf_lh, rd_nonzero(), word_addr() + off);
            load(rf_lhu, rd_nonzero(), word_addr() + off);
        end
        check_regs();

        // Back-to-back mix through memory ops
        for (int i = 0; i < 30; i++)
        begin
            case (rand_word() % 4)
                0:       alu_op(non_mem_sel(rand_word() % 4), rd_rand(), 1'b1);
                1:       load(rf_lw, rd_nonzero(), word_addr());
                2:       load(rf_lbu, rd_nonzero(), word_addr() + rand_word() % 4);
                default: store(size_byte, word_addr() + rand_word() % 4, rand_word());
            endcase
        end
        check_regs();

        $display("Error counts: %0d mismatches, %0d other failures, 0 timeouts",
                 mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
